// ==== source/pfb_pkg.sv ====
`default_nettype none

package pfb_pkg;

    //////////////////////////////
    // Pixel payload
    //////////////////////////////

    // Bits per pixel
    localparam int PIXEL_WIDTH = 16;

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    //////////////////////////////
    // Geometry
    //////////////////////////////

    // Default row buffer depth in pixels
    localparam int MAX_COLS_DEF = 64;

    // Output row or column index
    // 2*64+2 output columns still fit
    typedef logic [7:0] coord_t;

    //////////////////////////////
    // Job control
    //////////////////////////////

    // Idle, waiting for a row, streaming a row, closing the job
    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_stream,
        st_done
    } job_state_t;

endpackage

`default_nettype wire

// ==== source/row_buf_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module row_buf_ram #(
    parameter int MAX_COLS = pfb_pkg::MAX_COLS_DEF
) (
    input  wire logic              rd_clk,
    // Write port
    input  wire logic              wr_en,
    input  wire pfb_pkg::coord_t   wr_addr,
    input  wire pfb_pkg::pixel_t   din,
    // Read port
    input  wire logic              rd_en,
    input  wire pfb_pkg::coord_t   rd_addr,
    output pfb_pkg::pixel_t        dout
);
    import pfb_pkg::*;

    // Index bits actually used by the array
    localparam int AW = (MAX_COLS > 1) ? $clog2(MAX_COLS) : 1;

    // One input row
    pixel_t mem [MAX_COLS];

    //////////////////////////////
    // Write
    //////////////////////////////

    always_ff @(posedge rd_clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= din;
        end
    end

    //////////////////////////////
    // Registered read
    //////////////////////////////

    // Output holds when no read is issued
    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            dout <= mem[rd_addr[AW-1:0]];
        end
    end

    // Controller must keep both addresses inside the row
    a_addr_in_range: assert property (@(posedge rd_clk)
        (wr_en |-> wr_addr < MAX_COLS) and (rd_en |-> rd_addr < MAX_COLS))
        else $error("row_buf_ram address beyond MAX_COLS");

endmodule

`default_nettype wire

// ==== source/prefetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module prefetch_buffer #(
    parameter int MAX_COLS = pfb_pkg::MAX_COLS_DEF
) (
    input  wire logic              rd_clk,
    input  wire logic              rst,
    // Row data in and out
    input  wire pfb_pkg::pixel_t   din,
    input  wire logic              wr_en,
    input  wire logic              rd_en,
    output pfb_pkg::pixel_t        dout,
    // Job options
    input  wire logic              padding,
    input  wire logic              upsample,
    // Current output coordinate
    input  wire pfb_pkg::coord_t   out_row,
    input  wire pfb_pkg::coord_t   out_col,
    // Valid region bounds
    input  wire pfb_pkg::coord_t   vr_col_start,
    input  wire pfb_pkg::coord_t   vr_col_end,
    input  wire pfb_pkg::coord_t   vr_row_start,
    input  wire pfb_pkg::coord_t   vr_row_end,
    input  wire pfb_pkg::coord_t   in_cols,
    // Controller and sequencer events
    input  wire logic              job_fetch_ack,
    input  wire logic              job_complete_ack,
    input  wire logic              next_row,
    output logic                   cncl_fetch,
    output logic                   row_loaded
);
    import pfb_pkg::*;

    coord_t     wr_addr;
    logic       wr_last;
    coord_t     rd_addr;
    coord_t     addr_tbl [4];
    coord_t     seed [4];
    coord_t     step;
    logic [1:0] idx;
    logic       addr_clr;
    logic       row_in_vr;
    logic       zero_rd;
    logic       zero_q;
    logic       ram_rd;
    logic       repeat_row;
    logic       rd_active;
    pixel_t     ram_dout;

    row_buf_ram #(
        .MAX_COLS (MAX_COLS)
    ) u_ram (
        .rd_clk  (rd_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .din     (din),
        .rd_en   (ram_rd),
        .rd_addr (rd_addr),
        .dout    (ram_dout)
    );

    //////////////////////////////
    // Write side
    //////////////////////////////

    assign wr_last = (wr_addr == in_cols - 8'd1);

    // Count wraps on the last pixel, so a write in the ack cycle lands at 0
    always_ff @(posedge rd_clk) begin
        if (rst) begin
            wr_addr    <= '0;
            row_loaded <= 1'b0;
        end else begin
            row_loaded <= wr_en && wr_last;
            if (wr_en) begin
                wr_addr <= wr_last ? '0 : wr_addr + 8'd1;
            end else if (job_fetch_ack || job_complete_ack) begin
                wr_addr <= '0;
            end
        end
    end

    //////////////////////////////
    // Border and row repeat
    //////////////////////////////

    assign row_in_vr = (out_row >= vr_row_start) && (out_row <= vr_row_end);

    // Zero pixel outside the valid region
    assign zero_rd = padding && (!row_in_vr || out_col < vr_col_start
                                 || out_col > vr_col_end);

    // Border rows and copy rows reuse what is in the RAM
    assign cncl_fetch = (padding && !row_in_vr) || repeat_row;

    // Set after an even interior row when upsampling, cleared after the copy
    always_ff @(posedge rd_clk) begin
        if (rst || job_complete_ack) begin
            repeat_row <= 1'b0;
        end else if (next_row && upsample && row_in_vr) begin
            repeat_row <= ~repeat_row;
        end
    end

    //////////////////////////////
    // Read address pattern
    //////////////////////////////

    // Upsample walks 0,0,1,1,2,2..; plain mode walks 0,1,2,3..
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            seed[k] = upsample ? coord_t'(k >> 1) : coord_t'(k);
        end
        step = upsample ? 8'd2 : 8'd4;
    end

    // Every row restarts at pixel 0
    assign addr_clr = job_fetch_ack || job_complete_ack || next_row;
    assign ram_rd   = rd_en && !zero_rd;
    assign rd_addr  = addr_tbl[idx];

    // Border reads leave the table alone
    always_ff @(posedge rd_clk) begin
        if (rst || addr_clr) begin
            addr_tbl <= seed;
            idx      <= '0;
        end else if (ram_rd) begin
            addr_tbl[idx] <= addr_tbl[idx] + step;
            idx           <= idx + 2'd1;
        end
    end

    //////////////////////////////
    // Output masking
    //////////////////////////////

    // Mask lines up with the RAM read latency
    always_ff @(posedge rd_clk) begin
        if (rst) begin
            zero_q <= 1'b0;
        end else if (rd_en) begin
            zero_q <= zero_rd;
        end
    end

    assign dout = zero_q ? '0 : ram_dout;

    // Row in progress from first read until the row is handed on
    always_ff @(posedge rd_clk) begin
        if (rst || next_row || job_complete_ack) begin
            rd_active <= 1'b0;
        end else if (rd_en) begin
            rd_active <= 1'b1;
        end
    end

    // Single row buffer, so the source must wait for the stream to finish
    a_no_write_during_read: assert property (@(posedge rd_clk) disable iff (rst)
        rd_active |-> !wr_en)
        else $error("prefetch_buffer written while a row is being read");

endmodule

`default_nettype wire

// ==== source/window_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module window_sequencer (
    input  wire logic                 rd_clk,
    input  wire logic                 rst,
    input  wire logic                 stream_go,
    // Output image size
    input  wire pfb_pkg::coord_t      out_cols,
    input  wire pfb_pkg::coord_t      out_rows,
    // Read requests to the buffer
    output logic                      rd_en,
    output pfb_pkg::coord_t           out_row,
    output pfb_pkg::coord_t           out_col,
    output logic                      next_row,
    output logic                      row_done,
    output logic                      seq_done,
    // Output stream
    input  wire pfb_pkg::pixel_t      dout_buf,
    output logic                      pix_valid,
    output pfb_pkg::pixel_t           pix_out,
    output logic                      row_end,
    input  wire pfb_pkg::job_state_t  state
);
    import pfb_pkg::*;

    logic active;
    logic last_col;
    logic last_row;

    assign last_col = (out_col == out_cols - 8'd1);
    assign last_row = (out_row == out_rows - 8'd1);

    // One read per cycle while a row runs
    assign rd_en    = active;
    assign row_done = active && last_col;
    // Last row of the job hands over to seq_done instead
    assign next_row = row_done && !last_row;

    //////////////////////////////
    // Row walk
    //////////////////////////////

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            active  <= 1'b0;
            out_col <= '0;
            out_row <= '0;
        end else begin
            if (stream_go) begin
                active <= 1'b1;
            end else if (row_done) begin
                active <= 1'b0;
            end
            if (active) begin
                if (last_col) begin
                    out_col <= '0;
                    // Back to row 0, ready for the next job
                    out_row <= last_row ? '0 : out_row + 8'd1;
                end else begin
                    out_col <= out_col + 8'd1;
                end
            end
        end
    end

    //////////////////////////////
    // Output alignment
    //////////////////////////////

    // Buffer data arrives one cycle after the read
    always_ff @(posedge rd_clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
            row_end   <= 1'b0;
            seq_done  <= 1'b0;
        end else begin
            pix_valid <= rd_en;
            row_end   <= row_done;
            seq_done  <= row_done && last_row;
        end
    end

    assign pix_out = dout_buf;

    // Reads only happen with the controller in its streaming state
    a_rd_in_stream: assert property (@(posedge rd_clk) disable iff (rst)
        rd_en |-> state == st_stream)
        else $error("window_sequencer read outside st_stream");

endmodule

`default_nettype wire

// ==== source/job_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module job_ctrl #(
    parameter int MAX_COLS = pfb_pkg::MAX_COLS_DEF
) (
    input  wire logic              rd_clk,
    input  wire logic              rst,
    // Job request
    input  wire logic              job_start,
    input  wire pfb_pkg::coord_t   cfg_cols,
    input  wire pfb_pkg::coord_t   cfg_rows,
    input  wire logic              cfg_padding,
    input  wire logic              cfg_upsample,
    // Registered job setup
    output logic                   padding,
    output logic                   upsample,
    output pfb_pkg::coord_t        out_cols,
    output pfb_pkg::coord_t        out_rows,
    output pfb_pkg::coord_t        in_cols,
    output pfb_pkg::coord_t        vr_col_start,
    output pfb_pkg::coord_t        vr_col_end,
    output pfb_pkg::coord_t        vr_row_start,
    output pfb_pkg::coord_t        vr_row_end,
    // Row events
    input  wire logic              cncl_fetch,
    input  wire logic              row_loaded,
    input  wire logic              row_done,
    input  wire logic              seq_done,
    output logic                   fetch_req,
    output logic                   stream_go,
    output logic                   job_fetch_ack,
    output logic                   job_complete_ack,
    output logic                   job_done,
    output pfb_pkg::job_state_t    state
);
    import pfb_pkg::*;

    logic   start_ok;
    logic   row_done_q;
    coord_t cols_n;
    coord_t rows_n;

    // Doubled when upsampling, plus the two border pixels
    function automatic coord_t out_size(coord_t n, logic pad, logic up);
        coord_t s;
        s = up ? coord_t'(n << 1) : n;
        return pad ? s + 8'd2 : s;
    endfunction

    assign start_ok = job_start && (state == st_idle);
    assign cols_n   = out_size(cfg_cols, cfg_padding, cfg_upsample);
    assign rows_n   = out_size(cfg_rows, cfg_padding, cfg_upsample);

    //////////////////////////////
    // Job setup
    //////////////////////////////

    always_ff @(posedge rd_clk) begin
        if (start_ok) begin
            in_cols      <= cfg_cols;
            out_cols     <= cols_n;
            out_rows     <= rows_n;
            // Interior starts past the border
            vr_col_start <= coord_t'(cfg_padding);
            vr_row_start <= coord_t'(cfg_padding);
            vr_col_end   <= cols_n - (cfg_padding ? 8'd2 : 8'd1);
            vr_row_end   <= rows_n - (cfg_padding ? 8'd2 : 8'd1);
        end
    end

    //////////////////////////////
    // Job FSM
    //////////////////////////////

    always_ff @(posedge rd_clk) begin
        if (rst) begin
            state            <= st_idle;
            padding          <= 1'b0;
            upsample         <= 1'b0;
            row_done_q       <= 1'b0;
            fetch_req        <= 1'b0;
            stream_go        <= 1'b0;
            job_fetch_ack    <= 1'b0;
            job_complete_ack <= 1'b0;
            job_done         <= 1'b0;
        end else begin
            // Strobes by default
            fetch_req        <= 1'b0;
            stream_go        <= 1'b0;
            job_fetch_ack    <= 1'b0;
            job_complete_ack <= 1'b0;
            job_done         <= 1'b0;
            // Buffer state for the new row settles one cycle after row_done
            row_done_q       <= row_done;
            case (state)
                st_idle: begin
                    if (start_ok) begin
                        padding  <= cfg_padding;
                        upsample <= cfg_upsample;
                        // Top border row needs no input
                        if (cfg_padding) begin
                            state     <= st_stream;
                            stream_go <= 1'b1;
                        end else begin
                            state         <= st_fetch;
                            fetch_req     <= 1'b1;
                            job_fetch_ack <= 1'b1;
                        end
                    end
                end
                st_fetch: begin
                    if (row_loaded) begin
                        state     <= st_stream;
                        stream_go <= 1'b1;
                    end
                end
                st_stream: begin
                    if (seq_done) begin
                        state            <= st_done;
                        job_complete_ack <= 1'b1;
                        job_done         <= 1'b1;
                    end else if (row_done_q) begin
                        if (cncl_fetch) begin
                            stream_go <= 1'b1;
                        end else begin
                            state         <= st_fetch;
                            fetch_req     <= 1'b1;
                            job_fetch_ack <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Row must fit the buffer
    a_cols_fit: assert property (@(posedge rd_clk) disable iff (rst)
        start_ok |-> cfg_cols <= MAX_COLS)
        else $error("job_ctrl cfg_cols %0d exceeds MAX_COLS", cfg_cols);

endmodule

`default_nettype wire

// ==== source/pfb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pfb_top #(
    parameter int MAX_COLS = pfb_pkg::MAX_COLS_DEF
) (
    input  wire logic              rd_clk,
    input  wire logic              rst,
    // Job start
    input  wire logic              job_start,
    input  wire pfb_pkg::coord_t   cfg_cols,
    input  wire pfb_pkg::coord_t   cfg_rows,
    input  wire logic              cfg_padding,
    input  wire logic              cfg_upsample,
    // Row source
    output logic                   fetch_req,
    input  wire logic              wr_en,
    input  wire pfb_pkg::pixel_t   din,
    // Pixel stream
    output logic                   pix_valid,
    output pfb_pkg::pixel_t        pix_out,
    output logic                   row_end,
    output logic                   job_done
);
    import pfb_pkg::*;

    logic       padding;
    logic       upsample;
    coord_t     out_cols;
    coord_t     out_rows;
    coord_t     in_cols;
    coord_t     vr_col_start;
    coord_t     vr_col_end;
    coord_t     vr_row_start;
    coord_t     vr_row_end;
    logic       stream_go;
    logic       job_fetch_ack;
    logic       job_complete_ack;
    logic       cncl_fetch;
    logic       row_loaded;
    logic       rd_en;
    coord_t     out_row;
    coord_t     out_col;
    logic       next_row;
    logic       row_done;
    logic       seq_done;
    pixel_t     buf_dout;
    job_state_t state;

    //////////////////////////////
    // Controller
    //////////////////////////////

    job_ctrl #(
        .MAX_COLS (MAX_COLS)
    ) u_job_ctrl (
        .rd_clk           (rd_clk),
        .rst              (rst),
        .job_start        (job_start),
        .cfg_cols         (cfg_cols),
        .cfg_rows         (cfg_rows),
        .cfg_padding      (cfg_padding),
        .cfg_upsample     (cfg_upsample),
        .padding          (padding),
        .upsample         (upsample),
        .out_cols         (out_cols),
        .out_rows         (out_rows),
        .in_cols          (in_cols),
        .vr_col_start     (vr_col_start),
        .vr_col_end       (vr_col_end),
        .vr_row_start     (vr_row_start),
        .vr_row_end       (vr_row_end),
        .cncl_fetch       (cncl_fetch),
        .row_loaded       (row_loaded),
        .row_done         (row_done),
        .seq_done         (seq_done),
        .fetch_req        (fetch_req),
        .stream_go        (stream_go),
        .job_fetch_ack    (job_fetch_ack),
        .job_complete_ack (job_complete_ack),
        .job_done         (job_done),
        .state            (state)
    );

    //////////////////////////////
    // Output walk
    //////////////////////////////

    window_sequencer u_window_sequencer (
        .rd_clk    (rd_clk),
        .rst       (rst),
        .stream_go (stream_go),
        .out_cols  (out_cols),
        .out_rows  (out_rows),
        .rd_en     (rd_en),
        .out_row   (out_row),
        .out_col   (out_col),
        .next_row  (next_row),
        .row_done  (row_done),
        .seq_done  (seq_done),
        .dout_buf  (buf_dout),
        .pix_valid (pix_valid),
        .pix_out   (pix_out),
        .row_end   (row_end),
        .state     (state)
    );

    //////////////////////////////
    // Row buffer
    //////////////////////////////

    prefetch_buffer #(
        .MAX_COLS (MAX_COLS)
    ) u_prefetch_buffer (
        .rd_clk           (rd_clk),
        .rst              (rst),
        .din              (din),
        .wr_en            (wr_en),
        .rd_en            (rd_en),
        .dout             (buf_dout),
        .padding          (padding),
        .upsample         (upsample),
        .out_row          (out_row),
        .out_col          (out_col),
        .vr_col_start     (vr_col_start),
        .vr_col_end       (vr_col_end),
        .vr_row_start     (vr_row_start),
        .vr_row_end       (vr_row_end),
        .in_cols          (in_cols),
        .job_fetch_ack    (job_fetch_ack),
        .job_complete_ack (job_complete_ack),
        .next_row         (next_row),
        .cncl_fetch       (cncl_fetch),
        .row_loaded       (row_loaded)
    );

endmodule

`default_nettype wire

// ==== tests/tb_pfb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_pfb_top;
    import pfb_pkg::*;

    localparam int MAX_TESTS = 16;

    logic   rd_clk;
    logic   rst;
    logic   job_start;
    coord_t cfg_cols;
    coord_t cfg_rows;
    logic   cfg_padding;
    logic   cfg_upsample;
    logic   fetch_req;
    logic   wr_en;
    pixel_t din;
    logic   pix_valid;
    pixel_t pix_out;
    logic   row_end;
    logic   job_done;

    // Golden tests with the pixels of all tests in two flat queues
    logic [8*24-1:0] t_name [MAX_TESTS];
    int     t_cols [MAX_TESTS];
    int     t_rows [MAX_TESTS];
    int     t_pad [MAX_TESTS];
    int     t_up [MAX_TESTS];
    int     t_in_base [MAX_TESTS];
    int     t_out_base [MAX_TESTS];
    pixel_t in_pix [$];
    pixel_t exp_pix [$];
    int     n_tests;
    logic   file_bad;

    // Run bookkeeping
    int     cycle;
    int     cycle_limit;
    int     test_errs;
    int     tests_passed;
    int     tests_failed;
    int     t;

    pfb_top dut (
        .rd_clk       (rd_clk),
        .rst          (rst),
        .job_start    (job_start),
        .cfg_cols     (cfg_cols),
        .cfg_rows     (cfg_rows),
        .cfg_padding  (cfg_padding),
        .cfg_upsample (cfg_upsample),
        .fetch_req    (fetch_req),
        .wr_en        (wr_en),
        .din          (din),
        .pix_valid    (pix_valid),
        .pix_out      (pix_out),
        .row_end      (row_end),
        .job_done     (job_done)
    );

    // 20 ns clock
    always #10 rd_clk = ~rd_clk;

    // Hard stop for a hung job
    always @(posedge rd_clk) begin
        cycle = cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, the job sequence never finished", cycle);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input int idx);
        if (got !== exp) begin
            $display("FAIL pix_out[%0d]: got %h, expected %h", idx, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_count(input string sig, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("FAIL %0s count: got %h, expected %h", sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0s: got %h, expected %h", sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic report_test(input logic [8*24-1:0] name);
        if (test_errs == 0) begin
            $display("PASS %0s", name);
            tests_passed++;
        end else begin
            $display("FAIL %0s with %0d errors", name, test_errs);
            tests_failed++;
        end
    endtask

    // Output side of one image dimension
    function automatic int out_dim(input int n, input int pad, input int up);
        return (up != 0 ? 2 * n : n) + (pad != 0 ? 2 : 0);
    endfunction

    //////////////////////////////
    // Golden file
    //////////////////////////////

    task automatic load_golden();
        int               fd;
        int               r;
        int               c;
        int               rr;
        int               p;
        int               u;
        int               n_in;
        int               n_out;
        int               v;
        int               k;
        int               total;
        logic [8*24-1:0]  tok;
        logic [8*128-1:0] line;
        n_tests  = 0;
        file_bad = 1'b0;
        total    = 0;
        fd = $fopen("tests/pfb_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file tests/pfb_golden.txt");
            file_bad = 1'b1;
        end else begin
            r = $fscanf(fd, "%s", tok);
            while (r == 1 && !file_bad && n_tests < MAX_TESTS) begin
                // Comment lines start with a lone hash
                if (tok == "#") begin
                    r = $fgets(line, fd);
                end else begin
                    if ($fscanf(fd, "%d %d %d %d", c, rr, p, u) != 4) begin
                        file_bad = 1'b1;
                    end
                    n_in  = c * rr;
                    n_out = out_dim(c, p, u) * out_dim(rr, p, u);
                    t_name[n_tests]     = tok;
                    t_cols[n_tests]     = c;
                    t_rows[n_tests]     = rr;
                    t_pad[n_tests]      = p;
                    t_up[n_tests]       = u;
                    t_in_base[n_tests]  = in_pix.size();
                    t_out_base[n_tests] = exp_pix.size();
                    for (k = 0; k < n_in + n_out; k++) begin
                        if ($fscanf(fd, "%h", v) != 1) begin
                            file_bad = 1'b1;
                        end
                        if (k < n_in) begin
                            in_pix.push_back(pixel_t'(v));
                        end else begin
                            exp_pix.push_back(pixel_t'(v));
                        end
                    end
                    total += n_in + n_out;
                    n_tests++;
                end
                r = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
        if (file_bad) begin
            $display("Golden file is malformed, a header or pixel could not be read");
        end
        cycle_limit = 4 * total + 200;
    endtask

    //////////////////////////////
    // Test phases
    //////////////////////////////

    // Nothing may come out before the first job
    task automatic check_idle(input int n);
        int k;
        test_errs = 0;
        for (k = 0; k < n; k++) begin
            @(negedge rd_clk);
            check_flag("fetch_req", fetch_req, 1'b0);
            check_flag("pix_valid", pix_valid, 1'b0);
            check_flag("row_end", row_end, 1'b0);
            check_flag("job_done", job_done, 1'b0);
        end
        report_test("idle_after_reset");
    endtask

    task automatic run_job(input int ti);
        int   out_w;
        int   out_h;
        int   n_out;
        int   budget;
        int   waited;
        int   pix;
        int   rows_seen;
        int   fetches;
        int   feed_row;
        int   feed_col;
        logic feeding;
        logic gap;
        logic done;
        logic restarted;
        out_w     = out_dim(t_cols[ti], t_pad[ti], t_up[ti]);
        out_h     = out_dim(t_rows[ti], t_pad[ti], t_up[ti]);
        n_out     = out_w * out_h;
        budget    = 4 * (t_cols[ti] * t_rows[ti] + n_out) + 50;
        test_errs = 0;
        waited    = 0;
        pix       = 0;
        rows_seen = 0;
        fetches   = 0;
        feed_row  = 0;
        feed_col  = 0;
        feeding   = 1'b0;
        gap       = 1'b0;
        done      = 1'b0;
        restarted = 1'b0;
        // Start strobe sampled at the next rising edge
        job_start    = 1'b1;
        cfg_cols     = coord_t'(t_cols[ti]);
        cfg_rows     = coord_t'(t_rows[ti]);
        cfg_padding  = t_pad[ti][0];
        cfg_upsample = t_up[ti][0];
        while (!done && waited < budget) begin
            @(negedge rd_clk);
            waited++;
            job_start = 1'b0;
            wr_en     = 1'b0;
            // Output stream
            if (pix_valid) begin
                if (pix < n_out) begin
                    check_pixel(pix_out, exp_pix[t_out_base[ti] + pix], pix);
                    check_flag("row_end", row_end, (pix % out_w) == (out_w - 1));
                end else begin
                    $display("Pixel %0d arrived beyond the end of the image", pix);
                    test_errs++;
                end
                pix++;
            end
            if (row_end) begin
                rows_seen++;
            end
            if (job_done) begin
                done = 1'b1;
            end
            // Mid-job start with another setup that the DUT must drop
            if (pix == 1 && !restarted) begin
                job_start    = 1'b1;
                cfg_cols     = cfg_cols + 8'd1;
                cfg_padding  = ~cfg_padding;
                cfg_upsample = ~cfg_upsample;
                restarted    = 1'b1;
            end
            // Row source
            if (fetch_req) begin
                fetches++;
                if (feed_row < t_rows[ti]) begin
                    feeding  = 1'b1;
                    feed_col = 0;
                    gap      = 1'b0;
                end
            end
            if (feeding) begin
                if (gap) begin
                    gap = 1'b0;
                end else begin
                    wr_en = 1'b1;
                    din   = in_pix[t_in_base[ti] + feed_row * t_cols[ti] + feed_col];
                    feed_col++;
                    // Idle cycle between pixels on odd rows
                    gap = (feed_row % 2) == 1;
                    if (feed_col == t_cols[ti]) begin
                        feeding = 1'b0;
                        feed_row++;
                    end
                end
            end
        end
        if (!done) begin
            $display("job_done never arrived within %0d cycles", budget);
            test_errs++;
        end
        check_count("pix_valid", coord_t'(pix), coord_t'(n_out));
        check_count("fetch_req", coord_t'(fetches), coord_t'(t_rows[ti]));
        check_count("row_end", coord_t'(rows_seen), coord_t'(out_h));
        report_test(t_name[ti]);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rd_clk       = 1'b0;
        rst          = 1'b1;
        job_start    = 1'b0;
        cfg_cols     = '0;
        cfg_rows     = '0;
        cfg_padding  = 1'b0;
        cfg_upsample = 1'b0;
        wr_en        = 1'b0;
        din          = '0;
        cycle        = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_golden();
        repeat (8) @(posedge rd_clk);
        @(negedge rd_clk);
        rst = 1'b0;
        check_idle(10);
        for (t = 0; t < n_tests; t++) begin
            run_job(t);
            // Let the FSM get back to idle
            repeat (2) @(negedge rd_clk);
        end
        $display("Summary %0d tests passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && !file_bad && n_tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/pfb_golden.txt ====
# Per test a header line with name cols rows padding upsample
# then the input pixels and the expected output pixels in row order, all in hex
plain_copy 4 3 0 0
11 12 13 14 21 22 23 24 31 32 33 34
11 12 13 14 21 22 23 24 31 32 33 34
padding 4 3 1 0
41 42 43 44 51 52 53 54 61 62 63 64
00 00 00 00 00 00 00 41 42 43 44 00
00 51 52 53 54 00 00 61 62 63 64 00
00 00 00 00 00 00
upsample 4 3 0 1
71 72 73 74 81 82 83 84 91 92 93 94
71 71 72 72 73 73 74 74 71 71 72 72 73 73 74 74
81 81 82 82 83 83 84 84 81 81 82 82 83 83 84 84
91 91 92 92 93 93 94 94 91 91 92 92 93 93 94 94
pad_upsample 4 3 1 1
a1 a2 a3 a4 b1 b2 b3 b4 c1 c2 c3 c4
00 00 00 00 00 00 00 00 00 00 00 a1 a1 a2 a2 a3 a3 a4 a4 00
00 a1 a1 a2 a2 a3 a3 a4 a4 00 00 b1 b1 b2 b2 b3 b3 b4 b4 00
00 b1 b1 b2 b2 b3 b3 b4 b4 00 00 c1 c1 c2 c2 c3 c3 c4 c4 00
00 c1 c1 c2 c2 c3 c3 c4 c4 00 00 00 00 00 00 00 00 00 00 00
restart_ignored 4 2 0 1
d1 d2 d3 d4 e1 e2 e3 e4
d1 d1 d2 d2 d3 d3 d4 d4 d1 d1 d2 d2 d3 d3 d4 d4
e1 e1 e2 e2 e3 e3 e4 e4 e1 e1 e2 e2 e3 e3 e4 e4
small_after_big 2 2 1 1
15 16 25 26
00 00 00 00 00 00 00 15 15 16 16 00 00 15 15 16 16 00
00 25 25 26 26 00 00 25 25 26 26 00 00 00 00 00 00 00

// ==== flist.f ====
source/pfb_pkg.sv
source/row_buf_ram.sv
source/prefetch_buffer.sv
source/window_sequencer.sv
source/job_ctrl.sv
source/pfb_top.sv
tests/tb_pfb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pfb_top testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_pfb_top \
    > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/Vtb_pfb_top > sim.log 2>&1
grep -q "^Testbench passed$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
